// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module dcache_tb -f verilog.f \
    --Mdir obj_dir -o dcache_sim \
    && { ./obj_dir/dcache_sim 2>&1 | tee sim.log; } \
    && grep -qx "Test OK" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: tests/dcache_chk.sv
`timescale 1ns/1ps

module dcache_chk (
    input logic                                 clk,
    input logic                                 rst,
    input logic                                 kill,
    input dcache_types::dcache_ctrl_fsm_state_t state,
    input logic                                 dfp_read,
    input logic                                 dfp_write,
    input logic                                 write_hit_rec,
    input logic                                 allocate_done
);

    import dcache_types::*;

    int failures = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Controller rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(dfp_read && dfp_write))
        else begin
            $error("dfp_read and dfp_write high in the same cycle");
            failures++;
        end

    // Reread after a write hit lasts one cycle.
    single_reread: assert property (@(posedge clk) disable iff (rst)
        write_hit_rec |=> !write_hit_rec)
        else begin
            $error("write_hit_rec high for two cycles in a row");
            failures++;
        end

    refill_in_allocate: assert property (@(posedge clk) disable iff (rst)
        allocate_done |-> state == ALLOCATE)
        else begin
            $error("allocate_done outside ALLOCATE");
            failures++;
        end

    kill_to_idle: assert property (@(posedge clk) disable iff (rst)
        kill |=> state == PASS_THRU)
        else begin
            $error("FSM not in PASS_THRU one cycle after kill");
            failures++;
        end

endmodule

// File: tests/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

    import dcache_types::*;

    localparam int          SET_BITS = 2;  // Four sets, so lines collide.
    localparam logic [31:0] BASE     = 32'h0000_1000;
    localparam logic [31:0] STRIDE   = 32'd32 << SET_BITS;  // Same set, next tag.
    localparam int          N_RAND   = 400;
    localparam int          N_OPS    = N_RAND + 12;

    logic        clk = 1'b0, rst = 1'b1, kill = 1'b0;
    logic [31:0] ufp_addr = '0, ufp_wdata = '0;
    logic [3:0]  ufp_rmask = '0, ufp_wmask = '0;
    logic        stall, ufp_resp, dfp_read, dfp_write;
    logic [31:0] ufp_rdata, dfp_addr;
    line_t       dfp_wdata;
    logic        dfp_ready = 1'b0, dfp_rvalid = 1'b0;
    line_t       dfp_rdata = '0;
    logic [31:0] dfp_raddr = '0;

    int cycle = 0, checks = 0, word_errors = 0, line_errors = 0, other_errors = 0;
    int writebacks = 0, reads_taken = 0;

    logic [7:0]  shadow [logic [31:0]];     // Architectural bytes.
    line_t       mem_store [logic [26:0]];  // Backing memory by line.
    logic [31:0] exp_addr[$], exp_data[$];
    bit          exp_load[$];
    int          exp_accept[$], exp_lat[$];
    logic [31:0] ret_addr[$];
    int          ret_due[$];
    bit          ret_stale[$];

    dcache #(.SET_BITS(SET_BITS)) u_dcache (.*);

    bind dcache_ctrl dcache_chk u_chk (
        .clk(clk), .rst(rst), .kill(kill), .state(state), .dfp_read(dfp_read),
        .dfp_write(dfp_write), .write_hit_rec(write_hit_rec), .allocate_done(allocate_done)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cycle++;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a << 7) ^ 32'h5a3c_96e1;
    endfunction

    function automatic logic [7:0] shadow_byte(input logic [31:0] a);
        logic [31:0] fill;
        fill = fill_word({a[31:2], 2'b00});
        if (shadow.exists(a)) return shadow[a];
        return fill[8 * a[1:0] +: 8];
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        logic [31:0] word;
        for (int b = 0; b < 4; b++) begin
            word[8 * b +: 8] = shadow_byte({addr[31:2], 2'b00} + 32'(b));
        end
        return word;
    endfunction

    function automatic line_t shadow_line(input logic [31:0] line_addr);
        line_t line;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[32 * w +: 32] = ref_read(line_addr + 32'(4 * w));
        end
        return line;
    endfunction

    function automatic line_t read_line(input logic [31:0] line_addr);
        line_t line;
        if (mem_store.exists(line_addr[31:OFFSET_BITS])) return mem_store[line_addr[31:5]];
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[32 * w +: 32] = fill_word(line_addr + 32'(4 * w));
        end
        return line;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks and verdict
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            word_errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        checks++;
        if (got !== exp) begin
            line_errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            other_errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        int errors;
        errors = word_errors + line_errors + other_errors + u_dcache.u_ctrl.u_chk.failures;
        $display("checks %0d, word errors %0d, line errors %0d, other errors %0d, assertions %0d",
                 checks, word_errors, line_errors, other_errors, u_dcache.u_ctrl.u_chk.failures);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    task automatic drop_oldest();
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
        void'(exp_load.pop_front());
        void'(exp_accept.pop_front());
        void'(exp_lat.pop_front());
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (ufp_resp && exp_addr.size() == 0) begin
                other_errors++;
                $display("Response at cycle %0d with no request outstanding", cycle);
            end else if (ufp_resp) begin
                if (exp_load[0]) check_word("ufp_rdata", ufp_rdata, exp_data[0]);
                if (exp_lat[0] != 0 && cycle - exp_accept[0] != exp_lat[0]) begin
                    other_errors++;
                    $display("Response to %h came %0d cycles after acceptance, not %0d",
                             exp_addr[0], cycle - exp_accept[0], exp_lat[0]);
                end
                drop_oldest();
            end
            if (dfp_write) check_line("dfp_wdata", dfp_wdata, shadow_line(dfp_addr));
            if (dfp_read && exp_addr.size() != 0) begin
                check_word("dfp_addr", dfp_addr, {exp_addr[0][31:OFFSET_BITS], 5'd0});
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        dfp_rvalid = 1'b0;
        if (!rst) begin
            if (ret_addr.size() != 0 && ret_due[0] <= cycle) begin
                dfp_rvalid = 1'b1;
                dfp_raddr  = ret_addr[0];
                dfp_rdata  = ret_stale[0] ? {8{32'hbad0_0bad}} : read_line(ret_addr[0]);
                void'(ret_addr.pop_front());
                void'(ret_due.pop_front());
                void'(ret_stale.pop_front());
            end
            dfp_ready = ($urandom % 4) != 0;
            if (dfp_ready && dfp_write) begin
                mem_store[dfp_addr[31:OFFSET_BITS]] = dfp_wdata;
                writebacks++;
            end
            if (dfp_ready && dfp_read) begin
                reads_taken++;
                if ($urandom % 4 == 0) begin  // Junk for an address no request uses.
                    ret_addr.push_back(dfp_addr ^ 32'h8000_0000);
                    ret_due.push_back(cycle + 1);
                    ret_stale.push_back(1'b1);
                end
                ret_addr.push_back(dfp_addr);
                ret_due.push_back(cycle + 2 + int'($urandom % 5));
                ret_stale.push_back(1'b0);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Returns on the falling edge after the request is accepted.
    task automatic send(input logic [31:0] addr, input logic [3:0] wmask,
                        input logic [31:0] wdata, input int latency);
        ufp_addr  = addr;
        ufp_rmask = (wmask == 4'h0) ? 4'hf : 4'h0;
        ufp_wmask = wmask;
        ufp_wdata = wdata;
        while (stall) @(negedge clk);
        exp_addr.push_back(addr);
        exp_data.push_back(ref_read(addr));
        exp_load.push_back(wmask == 4'h0);
        exp_accept.push_back(cycle);
        exp_lat.push_back(latency);
        for (int b = 0; b < 4; b++) begin
            if (wmask[b]) shadow[addr + 32'(b)] = wdata[8 * b +: 8];
        end
        @(negedge clk);
        ufp_rmask = '0;
        ufp_wmask = '0;
    endtask

    task automatic drain();
        while (exp_addr.size() != 0) @(negedge clk);
    endtask

    initial begin
        int wb_before;
        int rd_before;
        void'($urandom(32'h99fd_74f0));
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        send(BASE + 32'h8, 4'h0, '0, 0);         // Cold miss.
        send(BASE + 32'hc, 4'h0, '0, 1);         // Back-to-back hit.
        send(BASE + 32'hc, 4'b0110, 32'hdead_beef, 1);
        check_bit("stall", stall, 1'b0);         // Store answers without a stall.
        send(BASE + 32'hc, 4'h0, '0, 2);         // One reread cycle first.
        check_bit("stall", stall, 1'b1);
        @(negedge clk);
        check_bit("stall", stall, 1'b0);
        drain();

        wb_before = writebacks;
        send(BASE + STRIDE + 32'h4, 4'h0, '0, 0);  // Dirty victim.
        drain();
        if (writebacks == wb_before) begin
            other_errors++;
            $display("Miss to a set with a dirty line issued no writeback");
        end

        rd_before = reads_taken;
        send(BASE + 3 * STRIDE + 32'h20, 4'h0, '0, 0);
        while (reads_taken == rd_before) @(posedge clk);
        @(negedge clk);
        kill = 1'b1;  // Refill still outstanding.
        @(negedge clk);
        kill = 1'b0;
        drop_oldest();
        send(BASE + 2 * STRIDE + 32'h20, 4'h0, '0, 0);  // Killed line may return meanwhile.
        send(BASE + 3 * STRIDE + 32'h24, 4'h0, '0, 0);
        drain();

        for (int i = 0; i < N_RAND; i++) begin
            if ($urandom % 3 == 0) begin
                send(BASE + ($urandom % 12) * 32 + ($urandom % 8) * 4,
                     4'($urandom % 15) + 4'd1, $urandom, 0);
            end else begin
                send(BASE + ($urandom % 12) * 32 + ($urandom % 8) * 4, 4'h0, '0, 0);
            end
        end
        drain();
        finish_run();
    end

    initial begin
        repeat (N_OPS * 40 + 500) @(posedge clk);
        other_errors++;
        $display("Timeout: stall is %b and %0d requests never got a response",
                 stall, exp_addr.size());
        finish_run();
    end

endmodule

// File: verilog.f
verilog/dcache_types.sv
verilog/dcache_array.sv
verilog/dcache_lookup.sv
verilog/dcache_compare.sv
verilog/dcache_ctrl.sv
verilog/dcache.sv
tests/dcache_chk.sv
tests/dcache_tb.sv

// File: verilog/dcache.sv
`timescale 1ns/1ps

module dcache #(
    parameter int SET_BITS = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                kill,

    // Core side.
    input  logic [31:0]         ufp_addr,
    input  logic [3:0]          ufp_rmask,
    input  logic [3:0]          ufp_wmask,
    input  logic [31:0]         ufp_wdata,
    output logic                stall,
    output logic [31:0]         ufp_rdata,
    output logic                ufp_resp,

    // Memory side.
    output logic [31:0]         dfp_addr,
    output logic                dfp_read,
    output logic                dfp_write,
    output dcache_types::line_t dfp_wdata,
    input  logic                dfp_ready,
    input  dcache_types::line_t dfp_rdata,
    input  logic [31:0]         dfp_raddr,
    input  logic                dfp_rvalid
);

    import dcache_types::*;

    localparam int TAG_BITS = 32 - OFFSET_BITS - SET_BITS;

    typedef logic [TAG_BITS-1:0] tag_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wires
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [31:0]         req_addr;
    logic [3:0]          req_rmask;
    logic [3:0]          req_wmask;
    logic [31:0]         req_wdata;
    logic [SET_BITS-1:0] array_index;
    logic [SET_BITS-1:0] wr_index;

    tag_t                tag_rd, tag_wr;
    line_t               line_rd, line_wr;
    status_t             status_rd, status_wr;
    logic                tag_wr_en, line_wr_en, status_wr_en;

    logic                hit, dirty;
    logic                allocate_done, write_hit, write_hit_rec;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stages
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    dcache_lookup #(.SET_BITS(SET_BITS)) u_lookup (
        .clk, .rst, .stall, .kill,
        .ufp_addr, .ufp_rmask, .ufp_wmask, .ufp_wdata,
        .req_addr, .req_rmask, .req_wmask, .req_wdata,
        .array_index
    );

    dcache_compare #(.SET_BITS(SET_BITS)) u_compare (
        .req_addr, .req_rmask, .req_wmask, .req_wdata,
        .tag_rd, .line_rd, .status_rd,
        .write_hit, .write_hit_rec, .allocate_done, .dfp_write, .dfp_rdata,
        .hit, .dirty, .ufp_rdata, .ufp_resp, .dfp_addr, .dfp_wdata,
        .tag_wr_en, .line_wr_en, .status_wr_en,
        .tag_wr, .line_wr, .status_wr, .wr_index
    );

    dcache_ctrl u_ctrl (
        .clk, .rst, .kill, .hit, .dirty,
        .rmask (req_rmask),
        .wmask (req_wmask),
        .stall, .allocate_done, .write_hit, .write_hit_rec,
        .dfp_addr, .dfp_read, .dfp_write, .dfp_ready, .dfp_raddr, .dfp_rvalid
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Arrays
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    dcache_array #(.SET_BITS(SET_BITS), .T(status_t), .CLEAR_ON_RESET(1'b1)) u_status (
        .clk, .rst, .rd_index (array_index),
        .wr_en (status_wr_en), .wr_index, .wr_data (status_wr), .rd_data (status_rd)
    );

    dcache_array #(.SET_BITS(SET_BITS), .T(tag_t), .CLEAR_ON_RESET(1'b0)) u_tag (
        .clk, .rst, .rd_index (array_index),
        .wr_en (tag_wr_en), .wr_index, .wr_data (tag_wr), .rd_data (tag_rd)
    );

    dcache_array #(.SET_BITS(SET_BITS), .T(line_t), .CLEAR_ON_RESET(1'b0)) u_line (
        .clk, .rst, .rd_index (array_index),
        .wr_en (line_wr_en), .wr_index, .wr_data (line_wr), .rd_data (line_rd)
    );

endmodule

// File: verilog/dcache_array.sv
`timescale 1ns/1ps

module dcache_array #(
    parameter int  SET_BITS       = 4,
    parameter type T              = logic,
    parameter bit  CLEAR_ON_RESET = 1'b0
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [SET_BITS-1:0] rd_index,
    input  logic                wr_en,
    input  logic [SET_BITS-1:0] wr_index,
    input  T                    wr_data,
    output T                    rd_data
);

    localparam int DEPTH = 2 ** SET_BITS;

    T mem [DEPTH];

    // Read sees the old entry when the same set is written on this edge.
    always_ff @(posedge clk) begin
        if (CLEAR_ON_RESET && rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            rd_data <= '0;
        end else begin
            if (wr_en) begin
                mem[wr_index] <= wr_data;
            end
            rd_data <= mem[rd_index];
        end
    end

endmodule

// File: verilog/dcache_compare.sv
`timescale 1ns/1ps

module dcache_compare #(
    parameter  int SET_BITS = 4,
    localparam int TAG_BITS = 32 - dcache_types::OFFSET_BITS - SET_BITS
) (
    // Registered request.
    input  logic [31:0]           req_addr,
    input  logic [3:0]            req_rmask,
    input  logic [3:0]            req_wmask,
    input  logic [31:0]           req_wdata,

    // Array read data.
    input  logic [TAG_BITS-1:0]   tag_rd,
    input  dcache_types::line_t   line_rd,
    input  dcache_types::status_t status_rd,

    // From the controller.
    input  logic                  write_hit,
    input  logic                  write_hit_rec,
    input  logic                  allocate_done,
    input  logic                  dfp_write,

    input  dcache_types::line_t   dfp_rdata,

    output logic                  hit,
    output logic                  dirty,
    output logic [31:0]           ufp_rdata,
    output logic                  ufp_resp,
    output logic [31:0]           dfp_addr,
    output dcache_types::line_t   dfp_wdata,

    // Array writes.
    output logic                  tag_wr_en,
    output logic                  line_wr_en,
    output logic                  status_wr_en,
    output logic [TAG_BITS-1:0]   tag_wr,
    output dcache_types::line_t   line_wr,
    output dcache_types::status_t status_wr,
    output logic [SET_BITS-1:0]   wr_index
);

    import dcache_types::*;

    localparam int WORD_SEL_BITS = $clog2(WORDS_PER_LINE);

    logic                     req_present;
    logic [TAG_BITS-1:0]      req_tag;
    logic [SET_BITS-1:0]      req_set;
    logic [WORD_SEL_BITS-1:0] word_sel;
    logic [$clog2(LINE_BITS)-1:0] word_base;
    logic [31:0]              victim_addr;
    logic [31:0]              fill_addr;
    line_t                    merged_line;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lookup result
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign req_present = |req_rmask || |req_wmask;
    assign req_tag     = req_addr[31 -: TAG_BITS];
    assign req_set     = req_addr[OFFSET_BITS +: SET_BITS];
    assign word_sel    = req_addr[2 +: WORD_SEL_BITS];
    assign word_base   = {word_sel, 5'd0};  // Bit offset of the word.

    assign hit   = status_rd.valid && (tag_rd == req_tag);
    assign dirty = status_rd.valid && status_rd.dirty;

    assign ufp_rdata = line_rd[word_base +: 32];
    assign ufp_resp  = req_present && hit && !write_hit_rec;  // Stale set otherwise.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Store merge and array writes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        merged_line = line_rd;
        for (int b = 0; b < 4; b++) begin
            if (req_wmask[b]) begin
                merged_line[word_base + 8 * b +: 8] = req_wdata[8 * b +: 8];
            end
        end
    end

    assign wr_index     = req_set;
    assign tag_wr_en    = allocate_done;
    assign line_wr_en   = allocate_done || write_hit;
    assign status_wr_en = allocate_done || write_hit;

    assign tag_wr           = req_tag;
    assign line_wr          = allocate_done ? dfp_rdata : merged_line;
    assign status_wr.valid  = 1'b1;
    assign status_wr.dirty  = !allocate_done;  // Refill is clean.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign victim_addr = {tag_rd, req_set, {OFFSET_BITS{1'b0}}};
    assign fill_addr   = {req_addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    // Victim address only while the writeback strobe is up.
    assign dfp_addr  = dfp_write ? victim_addr : fill_addr;
    assign dfp_wdata = line_rd;

endmodule

// File: verilog/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic        clk,
    input  logic        rst,

    input  logic        kill,
    input  logic        hit,
    input  logic        dirty,
    input  logic [3:0]  rmask,
    input  logic [3:0]  wmask,

    output logic        stall,
    output logic        allocate_done,
    output logic        write_hit,
    output logic        write_hit_rec,

    // Memory port.
    input  logic [31:0] dfp_addr,
    output logic        dfp_read,
    output logic        dfp_write,
    input  logic        dfp_ready,
    input  logic [31:0] dfp_raddr,
    input  logic        dfp_rvalid
);

    import dcache_types::*;

    dcache_ctrl_fsm_state_t state;
    dcache_ctrl_fsm_state_t next_state;

    logic req_valid;
    logic refill_match;

    assign req_valid    = |rmask || |wmask;
    assign refill_match = dfp_rvalid && (dfp_raddr == dfp_addr);  // Drops stale returns.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= PASS_THRU;
        end else begin
            state <= next_state;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next state and strobes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        next_state    = state;
        allocate_done = 1'b0;
        write_hit     = 1'b0;
        dfp_read      = 1'b0;
        dfp_write     = 1'b0;

        unique case (state)
            PASS_THRU: begin
                if (req_valid && !write_hit_rec) begin
                    write_hit = hit && |wmask;
                    if (!hit) begin
                        dfp_write = dirty;  // Evict first.
                        dfp_read  = !dirty;
                        if (dfp_ready) begin
                            next_state = dirty ? WB : ALLOCATE;
                        end
                    end
                end
            end
            WB: begin
                dfp_read = 1'b1;
                if (dfp_ready) begin
                    next_state = ALLOCATE;
                end
            end
            ALLOCATE: begin
                if (refill_match) begin
                    allocate_done = 1'b1;
                    next_state    = ALLOCATE_STALL;
                end
            end
            ALLOCATE_STALL: next_state = PASS_THRU;
            default:        next_state = PASS_THRU;
        endcase

        // Abandon whatever miss is in flight.
        if (kill) begin
            next_state = PASS_THRU;
        end
    end

    // Miss, or the one-cycle reread after a write hit.
    assign stall = req_valid && (write_hit_rec || !hit);

    always_ff @(posedge clk) begin
        if (rst) begin
            write_hit_rec <= 1'b0;
        end else begin
            write_hit_rec <= write_hit && !write_hit_rec;
        end
    end

endmodule

// File: verilog/dcache_lookup.sv
`timescale 1ns/1ps

module dcache_lookup #(
    parameter int SET_BITS = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                kill,

    // Core request.
    input  logic [31:0]         ufp_addr,
    input  logic [3:0]          ufp_rmask,
    input  logic [3:0]          ufp_wmask,
    input  logic [31:0]         ufp_wdata,

    // Registered request for the compare stage.
    output logic [31:0]         req_addr,
    output logic [3:0]          req_rmask,
    output logic [3:0]          req_wmask,
    output logic [31:0]         req_wdata,

    output logic [SET_BITS-1:0] array_index
);

    import dcache_types::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            req_rmask <= '0;
            req_wmask <= '0;
        end else if (kill) begin
            req_rmask <= '0;  // Bubble.
            req_wmask <= '0;
        end else if (!stall) begin
            req_rmask <= ufp_rmask;
            req_wmask <= ufp_wmask;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            req_addr  <= ufp_addr;
            req_wdata <= ufp_wdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Array read index
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // While stalled the held set is reread every cycle, so a write hit
    // or a refill shows up in the compare stage one edge later.
    assign array_index = stall ? req_addr[OFFSET_BITS +: SET_BITS]
                               : ufp_addr[OFFSET_BITS +: SET_BITS];

endmodule

// File: verilog/dcache_types.sv
package dcache_types;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int OFFSET_BITS    = 5;  // 32-byte lines.
    localparam int WORD_BITS      = 32;
    localparam int WORDS_PER_LINE = 8;
    localparam int LINE_BITS      = WORD_BITS * WORDS_PER_LINE;

    typedef logic [LINE_BITS-1:0] line_t;

    // Per-set bookkeeping.
    typedef struct packed {
        logic valid;
        logic dirty;
    } status_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Miss controller
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        PASS_THRU      = 2'b00,  // Hits flow, misses launch.
        ALLOCATE       = 2'b01,  // Waiting on refill data.
        ALLOCATE_STALL = 2'b10,  // Arrays reread the new line.
        WB             = 2'b11   // Victim sent, read next.
    } dcache_ctrl_fsm_state_t;

endpackage
